// File: audio_pkg.sv
package audio_pkg;

    // ----------------------------------------
    // APB bus

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [ 7:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;   // always 1, no wait states
        logic        pslverr;
    } apb_rsp_t;

    // ----------------------------------------
    // datapath

    // gains are unsigned 4.4 fixed point, 16 is unity
    typedef struct packed {
        logic               mic_en;
        logic               tone_en;
        logic        [ 7:0] mic_gain;
        logic        [ 7:0] tone_gain;
        logic        [15:0] tone_half_period;  // in sample frames
        logic signed [15:0] tone_level;
    } audio_cfg_t;

    typedef struct packed {
        logic               valid;
        logic signed [15:0] data;
    } sample_t;

    typedef struct packed {
        logic               valid;
        logic signed [23:0] data;
    } mic_sample_t;

    // ----------------------------------------
    // register map

    localparam logic [7:0] addr_ctrl       = 8'h00;
    localparam logic [7:0] addr_mic_gain   = 8'h04;
    localparam logic [7:0] addr_tone_gain  = 8'h08;
    localparam logic [7:0] addr_tone_half  = 8'h0C;
    localparam logic [7:0] addr_tone_level = 8'h10;
    localparam logic [7:0] addr_peak       = 8'h14;

    localparam int frame_bits = 64;  // bit clocks per stereo frame

endpackage

// File: apb_audio_regs.sv
`timescale 1ns/1ps

module apb_audio_regs
(
    input                          clk,
    input                          reset,
    input  audio_pkg::apb_req_t    apb_req,
    output audio_pkg::apb_rsp_t    apb_rsp,
    output audio_pkg::audio_cfg_t  cfg,
    input  audio_pkg::sample_t     mix_sample
);

    import audio_pkg::*;

    logic        access;
    logic        wr_en;
    logic        mapped;
    logic [31:0] rd_data;
    logic [15:0] peak;
    logic [15:0] sample_abs;

    assign access = apb_req.psel & apb_req.penable;  // access phase
    assign wr_en  = access & apb_req.pwrite;

    // ----------------------------------------
    // read mux and address decode

    always_comb
    begin
        mapped  = 1'b1;
        rd_data = '0;
        case (apb_req.paddr)
            addr_ctrl:       rd_data = {30'd0, cfg.tone_en, cfg.mic_en};
            addr_mic_gain:   rd_data = {24'd0, cfg.mic_gain};
            addr_tone_gain:  rd_data = {24'd0, cfg.tone_gain};
            addr_tone_half:  rd_data = {16'd0, cfg.tone_half_period};
            addr_tone_level: rd_data = {16'd0, cfg.tone_level};
            addr_peak:       rd_data = {16'd0, peak};
            default:         mapped  = 1'b0;
        endcase
    end

    assign apb_rsp = '{prdata: rd_data, pready: 1'b1, pslverr: access & ~mapped};

    // ----------------------------------------
    // configuration registers

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg <= '{mic_en: 1'b0, tone_en: 1'b0, mic_gain: 8'd16, tone_gain: 8'd16,
                     tone_half_period: 16'd8, tone_level: 16'h1000};
        end
        else if (wr_en)
        begin
            case (apb_req.paddr)
                addr_ctrl:
                begin
                    cfg.mic_en  <= apb_req.pwdata[0];
                    cfg.tone_en <= apb_req.pwdata[1];
                end
                addr_mic_gain:   cfg.mic_gain         <= apb_req.pwdata[7:0];
                addr_tone_gain:  cfg.tone_gain        <= apb_req.pwdata[7:0];
                addr_tone_half:  cfg.tone_half_period <= apb_req.pwdata[15:0];
                addr_tone_level: cfg.tone_level       <= apb_req.pwdata[15:0];
                default:         ;  // peak is cleared below, unmapped does nothing
            endcase
        end
    end

    // peak meter, -32768 folds onto 32767
    always_comb
    begin
        if (mix_sample.data == 16'h8000)
            sample_abs = 16'd32767;
        else if (mix_sample.data[15])
            sample_abs = -mix_sample.data;
        else
            sample_abs = mix_sample.data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            peak <= '0;
        else if (wr_en && apb_req.paddr == addr_peak)
            peak <= '0;                      // any write clears
        else if (mix_sample.valid && sample_abs > peak)
            peak <= sample_abs;
    end

endmodule

// File: i2s_mic_receiver.sv
`timescale 1ns/1ps

module i2s_mic_receiver
# (
    parameter int sck_half = 4
)
(
    input                           clk,
    input                           reset,
    input                           mic_en,
    output logic                    sck,
    output logic                    ws,
    input                           sd,
    output audio_pkg::mic_sample_t  sample
);

    import audio_pkg::*;

    localparam int div_w     = $clog2(sck_half + 1);
    localparam int cnt_w     = $clog2(frame_bits);
    localparam int data_bits = 24;

    logic [div_w     - 1:0] div_cnt;
    logic                   sck_toggle;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [cnt_w     - 1:0] bit_cnt;
    logic                   in_word;
    logic [data_bits - 2:0] shift;

    // ----------------------------------------
    // bit clock divider

    assign sck_toggle = (div_cnt == div_w'(sck_half - 1));
    assign sck_rise   = sck_toggle & ~sck;
    assign sck_fall   = sck_toggle &  sck;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_toggle)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // frame position advances on the falling edge, ws follows it
    always_ff @(posedge clk)
    begin
        if (reset)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    assign ws = bit_cnt[cnt_w - 1];  // low for the left half

    // ----------------------------------------
    // left word capture

    // MSB sits one bit clock after ws falls
    assign in_word = (bit_cnt >= cnt_w'(1)) && (bit_cnt <= cnt_w'(data_bits));

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_word)
            shift <= {shift[data_bits - 3:0], sd};
    end

    // the strobe runs every frame so the tone keeps stepping with the mic off
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sample <= '0;
        end
        else
        begin
            sample.valid <= 1'b0;
            if (sck_rise && bit_cnt == cnt_w'(data_bits))
            begin
                sample.valid <= 1'b1;
                sample.data  <= mic_en ? {shift, sd} : '0;  // last bit taken straight from sd
            end
        end
    end

endmodule

// File: tone_generator.sv
`timescale 1ns/1ps

module tone_generator
(
    input                          clk,
    input                          reset,
    input  audio_pkg::audio_cfg_t  cfg,
    input                          step,
    output logic signed [15:0]     tone_sample
);

    logic [15:0] step_cnt;
    logic        negative;
    logic        half_done;

    // widened by one bit so a count of 16'hffff cannot wrap
    assign half_done = ({1'b0, step_cnt} + 17'd1) >= {1'b0, cfg.tone_half_period};

    // ----------------------------------------
    // half period counter

    always_ff @(posedge clk)
    begin
        if (reset || !cfg.tone_en)
        begin
            step_cnt <= '0;
            negative <= 1'b0;       // restart on the positive half
        end
        else if (step)
        begin
            if (half_done)
            begin
                step_cnt <= '0;
                negative <= ~negative;
            end
            else
            begin
                step_cnt <= step_cnt + 16'd1;
            end
        end
    end

    // output only moves on a step or a register write
    always_comb
    begin
        if (!cfg.tone_en)
            tone_sample = '0;
        else if (negative)
            tone_sample = -cfg.tone_level;
        else
            tone_sample = cfg.tone_level;
    end

endmodule

// File: audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer
(
    input                           clk,
    input                           reset,
    input  audio_pkg::audio_cfg_t   cfg,
    input  audio_pkg::mic_sample_t  mic,
    input  logic signed [15:0]      tone_sample,
    output audio_pkg::sample_t      mix
);

    logic signed [15:0] mic_word;
    logic signed [24:0] mic_term;
    logic signed [24:0] tone_term;
    logic signed [25:0] sum;
    logic signed [21:0] scaled;
    logic signed [15:0] sat;

    assign mic_word = mic.data[23:8];  // top 16 of the 24 bit sample

    // ----------------------------------------
    // gain stage, 16 x 9 bit signed products

    always_comb
    begin
        mic_term  = '0;
        tone_term = '0;
        if (cfg.mic_en)
            mic_term = mic_word * $signed({1'b0, cfg.mic_gain});
        if (cfg.tone_en)
            tone_term = tone_sample * $signed({1'b0, cfg.tone_gain});
    end

    assign sum    = mic_term + tone_term;
    assign scaled = sum[25:4];   // arithmetic shift right by 4

    // clip to the 16 bit signed range
    always_comb
    begin
        if (scaled > 22'sd32767)
            sat = 16'sh7fff;
        else if (scaled < -22'sd32768)
            sat = 16'sh8000;
        else
            sat = scaled[15:0];
    end

    // ----------------------------------------
    // output register, one cycle after the mic strobe

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mix <= '0;
        end
        else
        begin
            mix.valid <= mic.valid;
            if (mic.valid)
                mix.data <= sat;
        end
    end

endmodule

// File: i2s_audio_out.sv
`timescale 1ns/1ps

module i2s_audio_out
# (
    parameter int sck_half = 4
)
(
    input                        clk,
    input                        reset,
    input  audio_pkg::sample_t   sample,
    output logic                 bclk,
    output logic                 lrclk,
    output logic                 sdata
);

    import audio_pkg::*;

    localparam int div_w       = $clog2(sck_half + 1);
    localparam int cnt_w       = $clog2(frame_bits);
    localparam int half_bits   = frame_bits / 2;
    localparam int sample_bits = 16;

    logic [div_w       - 1:0] div_cnt;
    logic                     bclk_toggle;
    logic                     bclk_fall;
    logic [cnt_w       - 1:0] bit_cnt;
    logic [cnt_w       - 1:0] next_cnt;
    logic [cnt_w       - 2:0] slot;          // position inside one channel
    logic [sample_bits - 1:0] held;
    logic [sample_bits - 1:0] frame_word;
    logic [sample_bits - 1:0] shift;

    // ----------------------------------------
    // bit clock and word select

    assign bclk_toggle = (div_cnt == div_w'(sck_half - 1));
    assign bclk_fall   = bclk_toggle & bclk;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (bclk_toggle)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign next_cnt = bit_cnt + 1'b1;
    assign slot     = next_cnt[cnt_w - 2:0];
    assign lrclk    = bit_cnt[cnt_w - 1];

    // newest sample wins, older ones are simply overwritten
    always_ff @(posedge clk)
    begin
        if (reset)
            held <= '0;
        else if (sample.valid)
            held <= sample.data;
    end

    // ----------------------------------------
    // serializer, data changes on the falling edge

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bit_cnt    <= '0;
            frame_word <= '0;
            shift      <= '0;
            sdata      <= 1'b0;
        end
        else if (bclk_fall)
        begin
            bit_cnt <= next_cnt;
            if (next_cnt == '0)
            begin
                frame_word <= held;            // one word for both channels
                shift      <= held;
                sdata      <= 1'b0;
            end
            else if (next_cnt == cnt_w'(half_bits))
            begin
                shift <= frame_word;           // right channel repeats the left
                sdata <= 1'b0;
            end
            else if (slot >= (cnt_w - 1)'(1) && slot <= (cnt_w - 1)'(sample_bits))
            begin
                sdata <= shift[sample_bits - 1];
                shift <= {shift[sample_bits - 2:0], 1'b0};
            end
            else
            begin
                sdata <= 1'b0;                 // padding after the LSB
            end
        end
    end

endmodule

// File: audio_subsystem_top.sv
`timescale 1ns/1ps

module audio_subsystem_top
# (
    parameter int sck_half = 4
)
(
    input                         clk,
    input                         reset,

    input  audio_pkg::apb_req_t   apb_req,
    output audio_pkg::apb_rsp_t   apb_rsp,

    output                        mic_sck,
    output                        mic_ws,
    input                         mic_sd,

    output                        i2s_bclk,
    output                        i2s_lrclk,
    output                        i2s_sdata
);

    import audio_pkg::*;

    audio_cfg_t         cfg;
    mic_sample_t        mic_sample;
    sample_t            mix_sample;
    logic signed [15:0] tone_sample;

    // ----------------------------------------

    apb_audio_regs i_regs
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .apb_req     ( apb_req     ),
        .apb_rsp     ( apb_rsp     ),
        .cfg         ( cfg         ),
        .mix_sample  ( mix_sample  )   // feeds the peak meter
    );

    i2s_mic_receiver # (.sck_half (sck_half)) i_microphone
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .mic_en      ( cfg.mic_en  ),
        .sck         ( mic_sck     ),
        .ws          ( mic_ws      ),
        .sd          ( mic_sd      ),
        .sample      ( mic_sample  )
    );

    // tone steps once per mic frame
    tone_generator i_tone
    (
        .clk         ( clk              ),
        .reset       ( reset            ),
        .cfg         ( cfg              ),
        .step        ( mic_sample.valid ),
        .tone_sample ( tone_sample      )
    );

    audio_mixer i_mixer
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cfg         ( cfg         ),
        .mic         ( mic_sample  ),
        .tone_sample ( tone_sample ),
        .mix         ( mix_sample  )
    );

    i2s_audio_out # (.sck_half (sck_half)) o_audio
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sample      ( mix_sample  ),
        .bclk        ( i2s_bclk    ),
        .lrclk       ( i2s_lrclk   ),
        .sdata       ( i2s_sdata   )
    );

endmodule

// File: audio_subsystem_checker.sv
`timescale 1ns/1ps

module audio_subsystem_checker
(
    input                       clk,
    input                       reset,
    input  audio_pkg::apb_req_t apb_req,
    input                       mic_sck,
    input                       mic_ws,
    input                       i2s_bclk,
    input                       i2s_lrclk
);

    // ----------------------------------------
    // APB protocol

    a_penable_psel: assert property (@(posedge clk) disable iff (reset)
        apb_req.penable |-> apb_req.psel)
        else $error("penable without psel");

    a_setup_access: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && !apb_req.penable |=> apb_req.penable && $stable(apb_req.paddr))
        else $error("setup not followed by a matching access cycle");

    // word selects move with the falling bit clock
    a_mic_ws: assert property (@(posedge clk) disable iff (reset)
        $changed(mic_ws) |-> $fell(mic_sck))
        else $error("mic ws changed away from a falling sck");

    a_out_lrclk: assert property (@(posedge clk) disable iff (reset)
        $changed(i2s_lrclk) |-> $fell(i2s_bclk))
        else $error("lrclk changed away from a falling bclk");

endmodule

bind audio_subsystem_top audio_subsystem_checker u_checker
(
    .clk (clk), .reset (reset), .apb_req (apb_req),
    .mic_sck (mic_sck), .mic_ws (mic_ws), .i2s_bclk (i2s_bclk), .i2s_lrclk (i2s_lrclk)
);

// File: tb_audio_subsystem.sv
`timescale 1ns/1ps

module tb_audio_subsystem;

    import audio_pkg::*;

    localparam int sck_half  = 4;
    localparam int max_cases = 32;

    logic     clk = 1'b0;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     mic_sck, mic_ws, mic_sd;
    logic     i2s_bclk, i2s_lrclk, i2s_sdata;

    string       c_name [max_cases];
    logic [31:0] c_ctrl [max_cases], c_mg [max_cases], c_tg [max_cases], c_half [max_cases];
    logic [31:0] c_lvl [max_cases], c_mic [max_cases], c_peak [max_cases];
    int          n_cases, errors, checks, mic_frames;
    int          cycles = 0;
    int          cycle_limit = 1000000;
    integer      seed = 32'h7812;

    logic [15:0] cur_mic = '0;
    logic [23:0] mic_word = '0;
    logic [31:0] rnd;
    logic        mic_sck_prev = 1'b0;
    int          mic_pos;
    logic        lr_prev = 1'b1;    // first rising bclk then counts as slot 0
    int          out_pos;
    logic [15:0] out_shift;
    logic [15:0] out_words[$];

    audio_subsystem_top #(.sck_half (sck_half)) u_dut
    (
        .clk (clk), .reset (reset), .apb_req (apb_req), .apb_rsp (apb_rsp),
        .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_sd (mic_sd),
        .i2s_bclk (i2s_bclk), .i2s_lrclk (i2s_lrclk), .i2s_sdata (i2s_sdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // microphone serializer that moves data after the falling sck

    always @(posedge clk)
    begin
        mic_sck_prev <= mic_sck;
        if (reset)
        begin
            mic_pos <= 0;
            mic_sd  <= 1'b0;
        end
        else if (mic_sck_prev && !mic_sck)
        begin
            // ws is low through the left half
            check_value("mic_ws", ((mic_pos + 1) % frame_bits) / (frame_bits / 2), mic_ws);
            if (mic_pos == frame_bits - 1)
            begin
                rnd = $random(seed);
                mic_pos    <= 0;
                mic_frames <= mic_frames + 1;
                mic_word   <= {cur_mic, rnd[7:0]};    // low bits are don't care
                mic_sd     <= 1'b0;
            end
            else
            begin
                mic_pos <= mic_pos + 1;
                mic_sd  <= (mic_pos < 24) ? mic_word[23 - mic_pos] : 1'b0;
            end
        end
    end

    // I2S output deserializer for the left words
    always @(posedge i2s_bclk)
    begin
        if (i2s_lrclk != lr_prev)
            out_pos = 0;
        else
            out_pos = out_pos + 1;
        lr_prev = i2s_lrclk;
        if (!i2s_lrclk && out_pos >= 1 && out_pos <= 16)
        begin
            out_shift = {out_shift[14:0], i2s_sdata};
            if (out_pos == 16)
                out_words.push_back(out_shift);
        end
    end

    // ----------------------------------------
    // helpers

    function automatic int mix_rule(logic [15:0] mic16, int mg, int tone, int tg,
                                    logic me, logic te);
        int s;
        s = 0;
        if (me)
            s = s + int'($signed(mic16)) * mg;
        if (te)
            s = s + tone * tg;
        s = s >>> 4;
        if (s > 32767)
            s = 32767;
        else if (s < -32768)
            s = -32768;
        return s;
    endfunction

    task automatic check_value(string name, int expected, int actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);             // response is stable mid access cycle
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        checks++;
        assert (apb_rsp.pready)
        else
        begin
            errors++;
            $display("pready was low during an access cycle");
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic read_check(string name, logic [7:0] addr, logic [31:0] expected);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_value(name, expected, rd);
        checks++;
        assert (!err)
        else
        begin
            errors++;
            $display("%s: a read of a mapped register raised pslverr", name);
        end
    endtask

    task automatic write_check(string name, logic [7:0] addr, logic [31:0] data,
                               logic [31:0] mask);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        read_check(name, addr, data & mask);
    endtask

    task automatic wait_frames(int n);
        int target;
        target = mic_frames + n;
        while (mic_frames < target)
            @(posedge clk);
    endtask

    // ----------------------------------------
    // main sequence

    initial
    begin
        int          fd;
        string       line;
        logic [31:0] rd;
        logic        err, saw_pos, saw_neg;
        int          e_pos, e_neg, w;

        reset      = 1'b1;
        apb_req    = '0;
        mic_sd     = 1'b0;
        mic_frames = 0;
        fd = $fopen("audio_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open audio_cases.txt");
            $display("STATUS: FAIL");
            $finish;
        end
        else
        begin
            void'($fgets(line, fd));    // column header
            while (n_cases < max_cases && $fscanf(fd, "%s %h %h %h %h %h %h %h",
                   c_name[n_cases], c_ctrl[n_cases], c_mg[n_cases], c_tg[n_cases],
                   c_half[n_cases], c_lvl[n_cases], c_mic[n_cases], c_peak[n_cases]) == 8)
                n_cases++;
            $fclose(fd);
            cycle_limit = n_cases * 8 * 512 + 20 * 512;

            repeat (4) @(posedge clk);
            reset <= 1'b0;

            read_check("reset_ctrl", addr_ctrl, 32'h0);
            read_check("reset_mic_gain", addr_mic_gain, 32'd16);
            read_check("reset_tone_gain", addr_tone_gain, 32'd16);
            read_check("reset_tone_half", addr_tone_half, 32'd8);
            read_check("reset_tone_level", addr_tone_level, 32'h1000);
            read_check("reset_peak", addr_peak, 32'h0);

            // unmapped address
            apb_xfer(1'b1, 8'h18, 32'hffffffff, rd, err);
            checks++;
            assert (err)
            else
            begin
                errors++;
                $display("a write to an unmapped address did not raise pslverr");
            end
            read_check("unmapped_ctrl", addr_ctrl, 32'h0);
            read_check("unmapped_mic_gain", addr_mic_gain, 32'd16);
            read_check("unmapped_tone_gain", addr_tone_gain, 32'd16);
            read_check("unmapped_tone_half", addr_tone_half, 32'd8);
            read_check("unmapped_tone_level", addr_tone_level, 32'h1000);
            read_check("unmapped_peak", addr_peak, 32'h0);

            for (int i = 0; i < n_cases; i++)
            begin
                cur_mic <= c_mic[i][15:0];
                write_check(c_name[i], addr_ctrl, c_ctrl[i], 32'h3);
                write_check(c_name[i], addr_mic_gain, c_mg[i], 32'hff);
                write_check(c_name[i], addr_tone_gain, c_tg[i], 32'hff);
                write_check(c_name[i], addr_tone_half, c_half[i], 32'hffff);
                write_check(c_name[i], addr_tone_level, c_lvl[i], 32'hffff);
                wait_frames(2);                           // let the new word settle
                apb_xfer(1'b1, addr_peak, '0, rd, err);
                out_words.delete();
                wait_frames(4);

                e_pos = mix_rule(c_mic[i][15:0], c_mg[i][7:0], int'($signed(c_lvl[i][15:0])),
                                 c_tg[i][7:0], c_ctrl[i][0], c_ctrl[i][1]);
                e_neg = mix_rule(c_mic[i][15:0], c_mg[i][7:0], -int'($signed(c_lvl[i][15:0])),
                                 c_tg[i][7:0], c_ctrl[i][0], c_ctrl[i][1]);
                saw_pos = 1'b0;
                saw_neg = 1'b0;
                if (out_words.size() < 3)
                begin
                    errors++;
                    $display("%s: fewer than 3 output words arrived", c_name[i]);
                end
                else
                begin
                    for (int k = out_words.size() - 3; k < out_words.size(); k++)
                    begin
                        w = int'($signed(out_words[k]));
                        saw_pos = saw_pos | (w == e_pos);
                        saw_neg = saw_neg | (w == e_neg);
                        if (c_ctrl[i][1])
                        begin
                            checks++;
                            assert (w == e_pos || w == e_neg)
                            else
                            begin
                                errors++;
                                $display("Error %s: expected %h or %h, actual %h",
                                         c_name[i], e_pos, e_neg, w);
                            end
                        end
                        else
                        begin
                            check_value(c_name[i], e_pos, w);
                        end
                    end
                    if (c_ctrl[i][1] && c_half[i] == 1)
                    begin
                        checks++;
                        assert (saw_pos && saw_neg)
                        else
                        begin
                            errors++;
                            $display("%s: the tone did not show both signs", c_name[i]);
                        end
                    end
                end
                read_check({c_name[i], "_peak"}, addr_peak, c_peak[i]);
            end

            // peak clear after the tone has filled the meter
            write_check("clear_tone_gain", addr_tone_gain, 32'd16, 32'hff);
            write_check("clear_tone_level", addr_tone_level, 32'h1000, 32'hffff);
            write_check("clear_tone_on", addr_ctrl, 32'h2, 32'h3);
            wait_frames(2);
            write_check("clear_ctrl", addr_ctrl, 32'h0, 32'h3);
            wait_frames(2);
            read_check("clear_peak_held", addr_peak, 32'h1000);   // level at unity gain
            apb_xfer(1'b1, addr_peak, '0, rd, err);
            read_check("clear_peak", addr_peak, 32'h0);

            $display("errors: %0d of %0d checks", errors, checks);
            if (errors == 0)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

// File: audio_cases.txt
# name ctrl mic_gain tone_gain tone_half tone_level mic16 peak (hex after name)
pass_unity 1 10 10 8 1000 1234 1234
pass_neg 1 10 10 8 1000 8765 789b
gain_x2 1 20 10 8 1000 0800 1000
gain_half 1 08 10 8 1000 4000 2000
clip_pos 1 40 10 8 1000 3000 7fff
clip_neg 1 40 10 8 1000 c000 7fff
tone_only 2 10 10 1 1000 7fff 1000
tone_gain 2 10 30 1 0800 2222 1800
tone_clip 2 10 ff 1 4000 0000 7fff
mixed 3 10 10 1 0400 1000 1400
all_off 0 10 10 8 1000 5555 0000

// File: vlog.f
audio_pkg.sv
apb_audio_regs.sv
i2s_mic_receiver.sv
tone_generator.sv
audio_mixer.sv
i2s_audio_out.sv
audio_subsystem_top.sv
audio_subsystem_checker.sv
tb_audio_subsystem.sv

// File: Bender.yml
package:
  name: audio_subsystem

sources:
  - audio_pkg.sv
  - apb_audio_regs.sv
  - i2s_mic_receiver.sv
  - tone_generator.sv
  - audio_mixer.sv
  - i2s_audio_out.sv
  - audio_subsystem_top.sv
  - target: test
    files:
      - audio_subsystem_checker.sv
      - tb_audio_subsystem.sv
